//--- lcd_bus_fsm.sv
module lcd_bus_fsm (
  input  logic                hwclk,
  input  logic                reset,
  // fifo read side
  input  logic                empty,
  input  lcd_pkg::lcd_entry_t pop_entry,
  output logic                pop,
  // phase timer
  output logic                load,
  input  logic                phase_done,
  // status and pins
  output logic                busy,
  output lcd_pkg::lcd_pins_t  pins
);

  import lcd_pkg::*;

  bus_state_t state_q;
  bus_state_t state_d;
  // byte currently on the bus
  lcd_entry_t entry_q;
  lcd_entry_t entry_d;
  lcd_pins_t  pins_q;

  // next state, pop and phase loads
  always_comb begin
    state_d = state_q;
    entry_d = entry_q;
    pop     = 1'b0;
    load    = 1'b0;
    case (state_q)
      idle: begin
        // take the head entry and start setup
        if (!empty) begin
          pop     = 1'b1;
          load    = 1'b1;
          entry_d = pop_entry;
          state_d = setup;
        end
      end
      setup: begin
        if (phase_done) begin
          load    = 1'b1;
          state_d = strobe;
        end
      end
      strobe: begin
        // wrx rises on leaving strobe, display latches here
        if (phase_done) begin
          load    = 1'b1;
          state_d = hold;
        end
      end
      hold: begin
        if (phase_done) begin
          if (!empty) begin
            // back to back, csx stays low
            pop     = 1'b1;
            load    = 1'b1;
            entry_d = pop_entry;
            state_d = setup;
          end else begin
            state_d = idle;
          end
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      state_q <= idle;
      entry_q <= entry_reset;
    end else begin
      state_q <= state_d;
      entry_q <= entry_d;
    end
  end

  // pins registered from next state so they switch with the state
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      pins_q <= pins_reset;
    end else begin
      pins_q.csx  <= (state_d == idle);
      pins_q.wrx  <= (state_d != strobe);
      // dcx and data hold their last value while idle
      pins_q.dcx  <= entry_d.is_data;
      pins_q.data <= entry_d.value;
    end
  end

  assign pins = pins_q;
  assign busy = (state_q != idle);

  // a write strobe never happens with the display deselected
  assert property (@(posedge hwclk) disable iff (reset) !pins.wrx |-> !pins.csx);

endmodule

//--- lcd_cmd_fifo.sv
module lcd_cmd_fifo #(
  parameter int DEPTH = lcd_pkg::fifo_depth
) (
  input  logic                hwclk,
  input  logic                reset,
  input  logic                push,
  input  lcd_pkg::lcd_entry_t push_entry,
  input  logic                pop,
  output lcd_pkg::lcd_entry_t pop_entry,
  output logic                full,
  output logic                empty,
  output lcd_pkg::fifo_cnt_t  count
);

  import lcd_pkg::*;

  // entry storage, power of two deep so pointers wrap on their own
  lcd_entry_t mem [DEPTH];

  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  fifo_cnt_t                count_q;

  // storage write, no reset on the array
  always_ff @(posedge hwclk) begin
    if (push) begin
      mem[wr_ptr_q] <= push_entry;
    end
  end

  // pointers and fill count
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves count as is
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // head of queue, valid whenever not empty
  assign pop_entry = mem[rd_ptr_q];

  assign full  = (count_q == fifo_cnt_t'(DEPTH));
  assign empty = (count_q == '0);
  assign count = count_q;

  // writers hold off on full, the reader only takes when something is queued
  assert property (@(posedge hwclk) disable iff (reset) !(push && full));
  assert property (@(posedge hwclk) disable iff (reset) !(pop && empty));

endmodule

//--- lcd_pkg.sv
package lcd_pkg;

  // widths that carry a meaning
  // one byte on the display data pins
  typedef logic [7:0]  lcd_byte_t;
  // register word address
  typedef logic [1:0]  wb_addr_t;
  typedef logic [31:0] wb_data_t;
  // phase divisor, a phase lasts divisor + 1 cycles
  typedef logic [7:0]  div_t;
  // fifo fill count, 0 to 8
  typedef logic [3:0]  fifo_cnt_t;

  // one queued byte, is_data is the dcx level
  typedef struct packed {
    logic      is_data;
    lcd_byte_t value;
  } lcd_entry_t;

  // display bus outputs, rdx is tied off at the top
  typedef struct packed {
    logic      csx;
    logic      dcx;
    logic      wrx;
    lcd_byte_t data;
  } lcd_pins_t;

  // write cycle phases
  typedef enum logic [1:0] {
    idle,
    setup,
    strobe,
    hold
  } bus_state_t;

  // register map
  localparam wb_addr_t addr_cmd    = 2'd0;
  localparam wb_addr_t addr_data   = 2'd1;
  localparam wb_addr_t addr_status = 2'd2;
  localparam wb_addr_t addr_div    = 2'd3;

  // busy flag sits just above the count in status
  localparam int stat_busy_bit = 4;

  // reset defaults
  localparam div_t       div_reset   = 8'd4;
  localparam int         fifo_depth  = 8;
  localparam lcd_entry_t entry_reset = '{is_data: 1'b0, value: 8'h00};
  localparam lcd_pins_t  pins_reset  = '{csx: 1'b1, dcx: 1'b0, wrx: 1'b1, data: 8'h00};

endpackage

//--- lcd_top.sv
module lcd_top (
  input  logic                hwclk,
  input  logic                reset,
  // wishbone classic slave
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  lcd_pkg::wb_addr_t   wb_adr,
  input  lcd_pkg::wb_data_t   wb_dat_w,
  output lcd_pkg::wb_data_t   wb_dat_r,
  output logic                wb_ack,
  // 8080 style display bus
  output logic                lcd_csx,
  output logic                lcd_dcx,
  output logic                lcd_wrx,
  output logic                lcd_rdx,
  output lcd_pkg::lcd_byte_t  lcd_data
);

  import lcd_pkg::*;

  // regs to fifo
  logic       push;
  lcd_entry_t push_entry;
  logic       full;
  fifo_cnt_t  count;
  // fifo to fsm
  logic       pop;
  lcd_entry_t pop_entry;
  logic       empty;
  // pacing
  div_t       divisor;
  logic       load;
  logic       phase_done;
  logic       busy;
  lcd_pins_t  pins;

  wb_lcd_regs u_regs (
    .hwclk      (hwclk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .push       (push),
    .push_entry (push_entry),
    .full       (full),
    .count      (count),
    .busy       (busy),
    .divisor    (divisor)
  );

  lcd_cmd_fifo #(
    .DEPTH (fifo_depth)
  ) u_fifo (
    .hwclk      (hwclk),
    .reset      (reset),
    .push       (push),
    .push_entry (push_entry),
    .pop        (pop),
    .pop_entry  (pop_entry),
    .full       (full),
    .empty      (empty),
    .count      (count)
  );

  strobe_timer u_timer (
    .hwclk      (hwclk),
    .reset      (reset),
    .load       (load),
    .divisor    (divisor),
    .phase_done (phase_done)
  );

  lcd_bus_fsm u_fsm (
    .hwclk      (hwclk),
    .reset      (reset),
    .empty      (empty),
    .pop_entry  (pop_entry),
    .pop        (pop),
    .load       (load),
    .phase_done (phase_done),
    .busy       (busy),
    .pins       (pins)
  );

  assign lcd_csx  = pins.csx;
  assign lcd_dcx  = pins.dcx;
  assign lcd_wrx  = pins.wrx;
  assign lcd_data = pins.data;
  // write-only bus, read strobe parked inactive
  assign lcd_rdx  = 1'b1;

endmodule

//--- project.f
lcd_pkg.sv
strobe_timer.sv
lcd_cmd_fifo.sv
wb_lcd_regs.sv
lcd_bus_fsm.sv
lcd_top.sv
tb_lcd_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_lcd_top -f project.f \
  || { echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_lcd_top | tee sim.log
grep -qx "Simulation passed" sim.log && exit 0 || exit 1

//--- strobe_timer.sv
module strobe_timer (
  input  logic          hwclk,
  input  logic          reset,
  input  logic          load,
  input  lcd_pkg::div_t divisor,
  output logic          phase_done
);

  import lcd_pkg::*;

  // remaining cycles in the current phase
  div_t cnt_q;
  // set by load and cleared when the phase ends
  logic active_q;

  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      cnt_q    <= '0;
      active_q <= 1'b0;
    end else if (load) begin
      // divisor sampled only here so a new value waits for the next phase
      cnt_q    <= divisor;
      active_q <= 1'b1;
    end else if (active_q) begin
      if (cnt_q == '0) begin
        // phase over and quiet until the next load
        active_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // last cycle of the phase
  // a load in the same cycle starts the next phase back to back
  assign phase_done = active_q && (cnt_q == '0);

endmodule

//--- tb_lcd_top.sv
module tb_lcd_top;

  timeunit 1ns;
  timeprecision 1ps;

  import lcd_pkg::*;

  // largest divisor used below sizes the hang limit
  localparam int max_div = 6;
  // 6 mixed bytes plus 12 burst bytes plus 4 + 4 divisor bytes
  localparam int n_bytes = 26;
  localparam int timeout_cycles = n_bytes * 3 * (max_div + 1) + 1000;

  logic      hwclk;
  logic      reset;
  logic      wb_cyc;
  logic      wb_stb;
  logic      wb_we;
  wb_addr_t  wb_adr;
  wb_data_t  wb_dat_w;
  wb_data_t  wb_dat_r;
  logic      wb_ack;
  logic      lcd_csx;
  logic      lcd_dcx;
  logic      lcd_wrx;
  logic      lcd_rdx;
  lcd_byte_t lcd_data;

  // entries written, in order, and entries seen on the pins
  lcd_entry_t exp_q[$];
  lcd_entry_t obs_q[$];
  lcd_entry_t got;
  lcd_entry_t want;
  lcd_entry_t mon_entry;
  int         pushed;
  int         seen;
  int         checks;
  int         errors;
  int         cycle_cnt;
  int         low_cycles;
  logic       wrx_prev;
  // divisor the bus is running with, only changed while drained
  div_t       exp_div;
  integer     seed;
  wb_addr_t   rnd_adr;
  wb_data_t   rnd_dat;
  wb_data_t   rd;

  lcd_top u_lcd_top (
    .hwclk    (hwclk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .lcd_csx  (lcd_csx),
    .lcd_dcx  (lcd_dcx),
    .lcd_wrx  (lcd_wrx),
    .lcd_rdx  (lcd_rdx),
    .lcd_data (lcd_data)
  );

  always #10 hwclk = ~hwclk;

  // dcx follows the address and the low byte goes out on the pins
  function automatic lcd_entry_t expected_entry(input wb_addr_t adr, input wb_data_t dat);
    lcd_entry_t e;
    e.is_data = (adr == addr_data);
    e.value   = dat[7:0];
    return e;
  endfunction

  task automatic check_value(input string what, input int got_v, input int want_v);
    checks++;
    assert (got_v == want_v) else begin
      errors++;
      $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got_v, want_v);
    end
  endtask

  // ack sampled mid-cycle and the access ends at the next edge
  task automatic wait_ack(output wb_data_t dat);
    @(negedge hwclk);
    while (!wb_ack) begin
      @(negedge hwclk);
    end
    dat = wb_dat_r;
    @(posedge hwclk);
    #1;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    if (adr == addr_cmd || adr == addr_data) begin
      exp_q.push_back(expected_entry(adr, dat));
      pushed++;
    end
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    // a full queue just stretches this wait
    wait_ack(unused);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    wait_ack(dat);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  // poll status until the queue and the bus are both empty
  task automatic drain_check();
    wb_data_t st;
    st = '1;
    while (st[$bits(fifo_cnt_t)-1:0] != '0 || st[stat_busy_bit]) begin
      wb_read(addr_status, st);
    end
    @(negedge hwclk);
    check_value("csx after drain", int'(lcd_csx), 1);
    check_value("bytes seen on the bus", seen, pushed);
    check_value("entries still expected", exp_q.size(), 0);
    @(posedge hwclk);
    #1;
  endtask

  task automatic set_divisor(input div_t d);
    wb_data_t back;
    wb_write(addr_div, wb_data_t'(d));
    exp_div = d;
    wb_read(addr_div, back);
    check_value("divisor readback", int'(back), int'(d));
  endtask

  // bus monitor on the falling edge where the pins are settled
  always @(negedge hwclk) begin
    if (!reset) begin
      if (!lcd_wrx) begin
        low_cycles++;
      end else if (!wrx_prev) begin
        // wrx just rose so the display latches this byte
        mon_entry.is_data = lcd_dcx;
        mon_entry.value   = lcd_data;
        obs_q.push_back(mon_entry);
        seen++;
        check_value("wrx low cycles", low_cycles, int'(exp_div) + 1);
        low_cycles = 0;
      end
      wrx_prev = lcd_wrx;
    end
  end

  // compare on the other edge from the monitor
  always @(posedge hwclk) begin
    if (obs_q.size() > 0) begin
      got = obs_q.pop_front();
      checks++;
      assert (exp_q.size() > 0) else begin
        errors++;
        $display("%0t: a byte appeared on the bus although nothing was written", $time);
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        assert (got == want) else begin
          errors++;
          $display("[ERROR] %0t: bus dcx=%0b data=%02h, expected dcx=%0b data=%02h",
                   $time, got.is_data, got.value, want.is_data, want.value);
        end
      end
    end
  end

  always @(posedge hwclk) begin
    cycle_cnt++;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: run did not finish within %0d cycles, the DUT seems hung", cycle_cnt);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    hwclk      = 1'b0;
    reset      = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    pushed     = 0;
    seen       = 0;
    checks     = 0;
    errors     = 0;
    cycle_cnt  = 0;
    low_cycles = 0;
    wrx_prev   = 1'b1;
    exp_div    = div_reset;
    seed       = 94204;
    repeat (5) @(posedge hwclk);
    #1;
    reset = 1'b0;

    // reset state of pins and registers
    @(negedge hwclk);
    check_value("csx after reset", int'(lcd_csx), 1);
    check_value("wrx after reset", int'(lcd_wrx), 1);
    check_value("rdx after reset", int'(lcd_rdx), 1);
    check_value("dcx after reset", int'(lcd_dcx), 0);
    check_value("ack after reset", int'(wb_ack), 0);
    @(posedge hwclk);
    #1;
    wb_read(addr_status, rd);
    check_value("status after reset", int'(rd), 0);
    wb_read(addr_div, rd);
    check_value("divisor after reset", int'(rd), int'(div_reset));
    // write-only address reads as zero
    wb_read(addr_cmd, rd);
    check_value("command register read", int'(rd), 0);

    // mixed command and data order
    wb_write(addr_cmd, 32'h2a);
    wb_write(addr_data, 32'h00);
    wb_write(addr_data, 32'h10);
    wb_write(addr_cmd, 32'h2c);
    wb_write(addr_data, 32'hab);
    wb_write(addr_data, 32'hcd);
    drain_check();

    // back-to-back burst longer than the queue
    repeat (12) begin
      rnd_adr = ($random(seed) & 1) ? addr_data : addr_cmd;
      rnd_dat = $random(seed);
      wb_write(rnd_adr, rnd_dat);
    end
    drain_check();

    // fast then slow strobes
    set_divisor(div_t'(1));
    wb_write(addr_cmd, 32'h36);
    wb_write(addr_data, 32'h48);
    wb_write(addr_cmd, 32'h3a);
    wb_write(addr_data, 32'h55);
    drain_check();
    set_divisor(div_t'(max_div));
    wb_write(addr_cmd, 32'h29);
    wb_write(addr_data, 32'hf0);
    wb_write(addr_data, 32'h0f);
    wb_write(addr_cmd, 32'h11);
    drain_check();

    $display("checks %0d, errors %0d, bytes pushed %0d, bytes seen %0d",
             checks, errors, pushed, seen);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- wb_lcd_regs.sv
module wb_lcd_regs (
  input  logic                hwclk,
  input  logic                reset,
  // wishbone classic slave
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  lcd_pkg::wb_addr_t   wb_adr,
  input  lcd_pkg::wb_data_t   wb_dat_w,
  output lcd_pkg::wb_data_t   wb_dat_r,
  output logic                wb_ack,
  // queue side
  output logic                push,
  output lcd_pkg::lcd_entry_t push_entry,
  input  logic                full,
  input  lcd_pkg::fifo_cnt_t  count,
  // status and pacing
  input  logic                busy,
  output lcd_pkg::div_t       divisor
);

  import lcd_pkg::*;

  logic     ack_q;
  wb_data_t dat_r_q;
  div_t     div_q;

  // request masked during the ack cycle so one access acts once
  logic     req;
  // write aimed at the command or data queue
  logic     queue_wr;
  // access that completes without waiting on the fifo
  logic     plain_acc;
  logic     div_wr;
  wb_data_t rd_mux;

  assign req       = wb_cyc && wb_stb && !ack_q;
  assign queue_wr  = wb_we && ((wb_adr == addr_cmd) || (wb_adr == addr_data));
  assign plain_acc = req && !queue_wr;
  assign div_wr    = plain_acc && wb_we && (wb_adr == addr_div);

  // push once space exists and hold back ack until then
  assign push = req && queue_wr && !full;

  // dcx level follows the address used
  assign push_entry.is_data = (wb_adr == addr_data);
  assign push_entry.value   = wb_dat_w[$bits(lcd_byte_t)-1:0];

  // read data mux with write-only addresses reading as zero
  always_comb begin
    rd_mux = '0;
    case (wb_adr)
      addr_status: begin
        rd_mux[$bits(fifo_cnt_t)-1:0] = count;
        rd_mux[stat_busy_bit]         = busy;
      end
      addr_div: begin
        rd_mux[$bits(div_t)-1:0] = div_q;
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  // one-cycle registered ack
  // queue writes ack the cycle after the push and everything else on the next cycle
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      ack_q   <= 1'b0;
      dat_r_q <= '0;
    end else begin
      ack_q <= push || plain_acc;
      if (plain_acc && !wb_we) begin
        dat_r_q <= rd_mux;
      end
    end
  end

  // divisor register while status writes are acked and dropped
  always_ff @(posedge hwclk, posedge reset) begin
    if (reset) begin
      div_q <= div_reset;
    end else if (div_wr) begin
      div_q <= wb_dat_w[$bits(div_t)-1:0];
    end
  end

  assign wb_ack   = ack_q;
  assign wb_dat_r = dat_r_q;
  assign divisor  = div_q;

  // master holds the request until it sees ack
  assert property (@(posedge hwclk) disable iff (reset) wb_ack |-> (wb_cyc && wb_stb));

endmodule
